// ==== hw/blur_pkg.sv ====
package blur_pkg;

	// image geometry
	localparam int CHAN_W = 8; // bits per colour channel
	localparam int LINE_WIDTH = 16; // pixels per line
	localparam int COL_W = 4; // column counter width

	// window and kernel
	localparam int KSIZE = 5;
	localparam int KCENTER = 2; // centre row and column of the window
	localparam int COEF_W = 8;
	localparam int ACC_W = 16; // product sum, bits 15..8 form the output

	// filter select encoding
	localparam logic FILT_PASS = 1'b0;
	localparam logic FILT_GAUSS = 1'b1;

	// 5x5 gaussian made symmetric, coefficients sum to 255
	localparam logic [KSIZE-1:0][KSIZE-1:0][COEF_W-1:0] GAUSS5 = '{
		'{8'd9, 8'd10, 8'd10, 8'd10, 8'd9},
		'{8'd10, 8'd11, 8'd11, 8'd11, 8'd10},
		'{8'd10, 8'd11, 8'd11, 8'd11, 8'd10},
		'{8'd10, 8'd11, 8'd11, 8'd11, 8'd10},
		'{8'd9, 8'd10, 8'd10, 8'd10, 8'd9}
	};

	// one pixel word, seen either raw or per channel
	typedef union packed {
		logic [3*CHAN_W-1:0] word; // r in the top byte, b in the bottom byte
		struct packed {
			logic [CHAN_W-1:0] r;
			logic [CHAN_W-1:0] g;
			logic [CHAN_W-1:0] b;
		} ch;
	} rgb_pixel_u;

endpackage

// ==== hw/blur_ifs.sv ====
`timescale 1ns/1ps

// one image column per transfer, from the line store to the window
interface column_if import blur_pkg::*; ();

	logic valid;
	logic sel; // filter select of the newest pixel
	rgb_pixel_u [KSIZE-1:0] pix; // [0] oldest line, [4] current pixel

	modport src (
		output valid,
		output sel,
		output pix
	);

	modport dst (
		input valid,
		input sel,
		input pix
	);

endinterface

// full 5x5 neighbourhood, from the window to the convolver
interface window_if import blur_pkg::*; ();

	logic valid;
	logic sel;
	rgb_pixel_u [KSIZE-1:0][KSIZE-1:0] win; // [row][col], row 4 newest line, col 4 newest

	modport src (
		output valid,
		output sel,
		output win
	);

	modport dst (
		input valid,
		input sel,
		input win
	);

endinterface

// ==== hw/pixel_line_store.sv ====
`timescale 1ns/1ps

module pixel_line_store import blur_pkg::*; (
	input logic clk,
	input logic rst,
	input logic pixel_valid,
	input logic frame_start,
	input logic filt_sel,
	input rgb_pixel_u pixel,
	column_if.src col
);

	// line_mem[KSIZE-2] holds the previous line, line_mem[0] the oldest one
	rgb_pixel_u line_mem [KSIZE-1][LINE_WIDTH];

	logic [COL_W-1:0] col_cnt;
	logic [COL_W-1:0] cur_col; // column of the incoming pixel
	rgb_pixel_u [KSIZE-2:0] line_rd; // stored pixels above the incoming one

	// frame_start forces column 0 for the pixel that carries it
	assign cur_col = frame_start ? '0 : col_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			col_cnt <= '0;
		end else if (pixel_valid) begin
			if (cur_col == COL_W'(LINE_WIDTH - 1)) begin
				col_cnt <= '0; // end of line
			end else begin
				col_cnt <= cur_col + 1'b1;
			end
		end
	end

	// asynchronous read of the four lines at the current column
	always_comb begin
		for (int k = 0; k < KSIZE-1; k++) begin
			line_rd[k] = line_mem[k][cur_col];
		end
	end

	// every line moves one step older at this column
	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			for (int k = 0; k < KSIZE-2; k++) begin
				line_mem[k][cur_col] <= line_rd[k+1];
			end
			line_mem[KSIZE-2][cur_col] <= pixel;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			col.valid <= 1'b0;
		end else begin
			col.valid <= pixel_valid;
		end
	end

	// column payload, held through idle cycles
	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			col.sel <= filt_sel;
			col.pix <= {pixel, line_rd}; // current pixel lands in pix[4]
		end
	end

	// the line memories are only LINE_WIDTH deep
	assert property (@(posedge clk) disable iff (rst)
		int'(col_cnt) < LINE_WIDTH)
	else
		$error("column counter out of range: %0d", col_cnt);

	// a frame marker without its pixel would be lost
	assert property (@(posedge clk) disable iff (rst)
		frame_start |-> pixel_valid)
	else
		$error("frame_start without pixel_valid");

endmodule

// ==== hw/window_shift.sv ====
`timescale 1ns/1ps

module window_shift import blur_pkg::*; (
	input logic clk,
	input logic rst,
	column_if.dst col,
	window_if.src win
);

	rgb_pixel_u [KSIZE-1:0][KSIZE-1:0] win_q; // [row][col]

	always_ff @(posedge clk) begin
		if (rst) begin
			win.valid <= 1'b0;
		end else begin
			win.valid <= col.valid;
		end
	end

	// shift toward column 0, new column enters at the right
	always_ff @(posedge clk) begin
		if (col.valid) begin
			win.sel <= col.sel;
			for (int row = 0; row < KSIZE; row++) begin
				for (int c = 0; c < KSIZE-1; c++) begin
					win_q[row][c] <= win_q[row][c+1];
				end
				win_q[row][KSIZE-1] <= col.pix[row];
			end
		end
	end

	assign win.win = win_q;

	// windows are never created or dropped here
	assert property (@(posedge clk) disable iff (rst)
		win.valid == $past(col.valid))
	else
		$error("window valid out of step with column valid");

endmodule

// ==== hw/blur_convolver.sv ====
`timescale 1ns/1ps

module blur_convolver import blur_pkg::*; (
	input logic clk,
	input logic rst,
	window_if.dst win,
	output logic out_valid,
	output rgb_pixel_u out_pixel
);

	logic [KSIZE-1:0][KSIZE-1:0][COEF_W-1:0] coef;

	// per channel sum, wide enough for 25 full-scale products
	logic [2:0][ACC_W+$clog2(KSIZE*KSIZE)-1:0] sum; // [2] r, [1] g, [0] b
	logic [2:0][ACC_W-1:0] acc;

	// kernel select
	always_comb begin
		coef = '0;
		case (win.sel)
			FILT_PASS: coef[KCENTER][KCENTER] = {COEF_W{1'b1}}; // 0xff at centre
			FILT_GAUSS: coef = GAUSS5;
			default: coef = '0;
		endcase
	end

	// multiply-accumulate over the window
	always_comb begin
		for (int ch = 0; ch < 3; ch++) begin
			sum[ch] = '0;
			for (int i = 0; i < KSIZE; i++) begin
				for (int j = 0; j < KSIZE; j++) begin
					sum[ch] = sum[ch]
						+ win.win[i][j].word[ch*CHAN_W +: CHAN_W] * coef[i][j];
				end
			end
			acc[ch] = sum[ch][ACC_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= win.valid;
		end
	end

	// keep bits 15..8, no saturation needed
	always_ff @(posedge clk) begin
		if (win.valid) begin
			for (int ch = 0; ch < 3; ch++) begin
				out_pixel.word[ch*CHAN_W +: CHAN_W] <= acc[ch][ACC_W-1 -: CHAN_W];
			end
		end
	end

	// both kernels sum to 255, so no channel can pass 16 bits
	assert property (@(posedge clk) disable iff (rst)
		win.valid |-> ((sum[0] | sum[1] | sum[2]) >> ACC_W) == '0)
	else
		$error("accumulator overflow r=%h g=%h b=%h", sum[2], sum[1], sum[0]);

	// a window that reached the output must have been fully filled
	assert property (@(posedge clk) disable iff (rst)
		out_valid |-> !$isunknown(out_pixel))
	else
		$error("out_pixel unknown while out_valid");

endmodule

// ==== hw/blur_top.sv ====
`timescale 1ns/1ps

module blur_top import blur_pkg::*; (
	input logic clk,
	input logic rst,
	input logic pixel_valid,
	input logic frame_start,
	input logic filt_sel,
	input logic [CHAN_W-1:0] r,
	input logic [CHAN_W-1:0] g,
	input logic [CHAN_W-1:0] b,
	output logic out_valid,
	output logic [CHAN_W-1:0] out_r,
	output logic [CHAN_W-1:0] out_g,
	output logic [CHAN_W-1:0] out_b
);

	rgb_pixel_u in_pixel;
	rgb_pixel_u out_pixel;

	column_if col_bus ();
	window_if win_bus ();

	always_comb begin
		in_pixel.ch.r = r;
		in_pixel.ch.g = g;
		in_pixel.ch.b = b;
	end

	pixel_line_store line_store0 (
		.clk(clk),
		.rst(rst),
		.pixel_valid(pixel_valid),
		.frame_start(frame_start),
		.filt_sel(filt_sel),
		.pixel(in_pixel),
		.col(col_bus.src)
	);

	window_shift window0 (
		.clk(clk),
		.rst(rst),
		.col(col_bus.dst),
		.win(win_bus.src)
	);

	blur_convolver conv0 (
		.clk(clk),
		.rst(rst),
		.win(win_bus.dst),
		.out_valid(out_valid),
		.out_pixel(out_pixel)
	);

	assign out_r = out_pixel.ch.r;
	assign out_g = out_pixel.ch.g;
	assign out_b = out_pixel.ch.b;

endmodule

// ==== verif/blur_tb.sv ====
`timescale 1ns/1ps

module blur_tb import blur_pkg::*; ();

	localparam int FRAME_LINES = 8;
	localparam int FRAME_PIX = FRAME_LINES * LINE_WIDTH;
	localparam int N_FRAMES = 5;
	localparam int MAX_GAP = 2; // idle cycles after a pixel, at most
	localparam int STIM_CYCLES = N_FRAMES * FRAME_PIX * (MAX_GAP + 1) + 20;
	localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 100;

	logic clk;
	logic rst;
	logic pixel_valid;
	logic frame_start;
	logic filt_sel;
	logic [CHAN_W-1:0] r;
	logic [CHAN_W-1:0] g;
	logic [CHAN_W-1:0] b;
	logic out_valid;
	logic [CHAN_W-1:0] out_r;
	logic [CHAN_W-1:0] out_g;
	logic [CHAN_W-1:0] out_b;

	logic [3*CHAN_W-1:0] frame_px [FRAME_LINES][LINE_WIDTH]; // {r, g, b}
	logic [3*CHAN_W:0] exp_q [$]; // {checked, pixel}
	logic exp_chk = 1'b0;
	logic [3*CHAN_W-1:0] exp_pix = '0;
	logic extra_out = 1'b0;
	logic [2:0] vld_hist;
	int cycles = 0;
	int n_checked = 0;
	int timing_errs = 0;
	int data_errs = 0;
	int other_errs = 0;

	blur_top dut0 (
		.clk(clk),
		.rst(rst),
		.pixel_valid(pixel_valid),
		.frame_start(frame_start),
		.filt_sel(filt_sel),
		.r(r),
		.g(g),
		.b(b),
		.out_valid(out_valid),
		.out_r(out_r),
		.out_g(out_g),
		.out_b(out_b)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (rst) begin
			vld_hist <= '0;
		end else begin
			vld_hist <= {vld_hist[1:0], pixel_valid}; // [2] is the pixel three edges back
		end
	end

	// output centred two lines up and two columns left of pixel (y, x)
	function automatic logic [3*CHAN_W-1:0] expected_pixel(input int y, input int x,
		input logic sel);
		logic [3*CHAN_W-1:0] res;
		int acc;
		res = '0;
		for (int ch = 0; ch < 3; ch++) begin
			acc = 0;
			if (sel == FILT_PASS) begin
				acc = int'(frame_px[y-KCENTER][x-KCENTER][ch*CHAN_W +: CHAN_W]) * 255;
			end else begin
				for (int i = 0; i < KSIZE; i++) begin
					for (int j = 0; j < KSIZE; j++) begin
						acc += int'(frame_px[y-KSIZE+1+i][x-KSIZE+1+j][ch*CHAN_W +: CHAN_W])
							* int'(GAUSS5[i][j]);
					end
				end
			end
			res[ch*CHAN_W +: CHAN_W] = CHAN_W'((acc >> 8) & 255);
		end
		return res;
	endfunction

	// kind 0 random, 1 flat fill, 2 single pixel of fill at line 3 column 7
	task automatic send_frame(input int kind, input logic [3*CHAN_W-1:0] fill,
		input logic sel_a, input logic sel_b, input int switch_at);
		logic [3*CHAN_W-1:0] px;
		logic sel;
		logic chk;
		int gap;
		for (int y = 0; y < FRAME_LINES; y++) begin
			for (int x = 0; x < LINE_WIDTH; x++) begin
				case (kind)
					0: px = 24'($urandom);
					1: px = fill;
					default: px = (y == 3 && x == 7) ? fill : '0;
				endcase
				sel = (y * LINE_WIDTH + x < switch_at) ? sel_a : sel_b;
				frame_px[y][x] = px;
				chk = (y >= KSIZE - 1) && (x >= KSIZE - 1); // window inside this frame
				@(negedge clk);
				pixel_valid = 1'b1;
				frame_start = (y == 0 && x == 0);
				filt_sel = sel;
				{r, g, b} = px;
				exp_q.push_back({chk, chk ? expected_pixel(y, x, sel) : 24'h0});
				gap = $urandom % (MAX_GAP + 1);
				repeat (gap) begin
					@(negedge clk);
					pixel_valid = 1'b0;
					frame_start = 1'b0;
				end
			end
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (out_valid) begin
			if (exp_q.size() == 0) begin
				extra_out = 1'b1;
				exp_chk = 1'b0;
			end else begin
				{exp_chk, exp_pix} = exp_q.pop_front();
				extra_out = 1'b0;
				if (exp_chk) n_checked++;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) out_valid == vld_hist[2])
	else begin
		timing_errs++;
		$display("FAIL out_valid expected %h got %h", $sampled(vld_hist[2]),
			$sampled(out_valid));
	end

	assert property (@(posedge clk) disable iff (rst) out_valid |-> !extra_out)
	else begin
		other_errs++;
		$display("out_valid came with no pixel waiting for a result");
	end

	assert property (@(posedge clk) disable iff (rst)
		(out_valid && exp_chk && !extra_out) |-> out_r == exp_pix[23:16])
	else begin
		data_errs++;
		$display("FAIL out_r expected %h got %h", $sampled(exp_pix[23:16]), $sampled(out_r));
	end

	assert property (@(posedge clk) disable iff (rst)
		(out_valid && exp_chk && !extra_out) |-> out_g == exp_pix[15:8])
	else begin
		data_errs++;
		$display("FAIL out_g expected %h got %h", $sampled(exp_pix[15:8]), $sampled(out_g));
	end

	assert property (@(posedge clk) disable iff (rst)
		(out_valid && exp_chk && !extra_out) |-> out_b == exp_pix[7:0])
	else begin
		data_errs++;
		$display("FAIL out_b expected %h got %h", $sampled(exp_pix[7:0]), $sampled(out_b));
	end

	initial begin
		wait (cycles >= CYCLE_LIMIT);
		$display("timeout after %0d cycles with %0d results outstanding", cycles, exp_q.size());
		$display("Test failures found");
		$finish;
	end

	initial begin
		logic [CHAN_W-1:0] spot;
		void'($urandom(32'h8156_c664));
		rst = 1'b1;
		pixel_valid = 1'b0;
		frame_start = 1'b0;
		filt_sel = FILT_PASS;
		r = '0;
		g = '0;
		b = '0;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		repeat (3) @(negedge clk); // out_valid must stay low here
		send_frame(0, '0, FILT_PASS, FILT_PASS, FRAME_PIX);
		send_frame(1, 24'($urandom), FILT_GAUSS, FILT_GAUSS, FRAME_PIX);
		spot = CHAN_W'($urandom % 255 + 1);
		send_frame(2, {8'h00, spot, 8'h00}, FILT_GAUSS, FILT_GAUSS, FRAME_PIX); // green only
		send_frame(0, '0, FILT_GAUSS, FILT_GAUSS, FRAME_PIX);
		send_frame(0, '0, FILT_GAUSS, FILT_PASS, FRAME_PIX / 2 + 5); // switch mid-frame
		@(negedge clk);
		pixel_valid = 1'b0;
		frame_start = 1'b0;
		while (exp_q.size() != 0) @(negedge clk);
		repeat (5) @(negedge clk);
		if (n_checked == 0) begin
			other_errs++;
			$display("no output was compared against the model");
		end
		$display("errors: timing=%0d data=%0d other=%0d, outputs checked=%0d",
			timing_errs, data_errs, other_errs, n_checked);
		if (timing_errs + data_errs + other_errs == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== list.f ====
hw/blur_pkg.sv
hw/blur_ifs.sv
hw/pixel_line_store.sv
hw/window_shift.sv
hw/blur_convolver.sv
hw/blur_top.sv
verif/blur_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the blur filter testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module blur_tb -f list.f -o blur_sim
out=$(./obj_dir/blur_sim)
echo "$out"
if echo "$out" | grep -q "All tests passed!"; then
	exit 0
fi
exit 1
